//--- compile.f
+incdir+src
src/bridge_pkg.sv
src/control_decoder.sv
src/write_deserializer.sv
src/ack_tracker.sv
src/read_serializer.sv
src/bridge_sequencer.sv
src/uart_bridge_slave.sv
verif/uart_bridge_slave_assert.sv
verif/tb_uart_bridge_slave.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the uart bridge slave testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tb_uart_bridge_slave -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/tb_uart_bridge_slave.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module tb_uart_bridge_slave;

    localparam int DW          = `BRIDGE_DATA_WIDTH;
    localparam int IW          = `BRIDGE_ID_WIDTH;
    localparam int RETX        = `BRIDGE_RETX_TIMES;
    localparam int CYCLE_LIMIT = 20000;
    localparam int TASK_LIMIT  = 2000;
    localparam logic [DW-1:0] ACK_WORD = {{(DW - 8){1'b0}}, 8'hCC};

    // write reply modes of the send-side board
    localparam int REPLY_ACK   = 0;
    localparam int REPLY_WRONG = 1;
    localparam int REPLY_NONE  = 2;

    logic          clk;
    logic          rstN;
    logic          control;
    logic          wD;
    logic          valid;
    logic          rD;
    logic          ready;
    logic          g_txStart;
    logic [DW-1:0] g_byteForTx;
    logic          g_txReady;
    logic          g_rxStart;
    logic          g_rxDone;
    logic [DW-1:0] g_byteFromRx;
    logic          g_rxReady;
    logic          s_rxStart;
    logic          s_rxDone;
    logic [DW-1:0] s_byteFromRx;
    logic          s_rxReady;
    logic          s_txStart;
    logic [DW-1:0] s_byteForTx;
    logic          s_txReady;

    logic [3:0] exp_status;
    int         cycle_count;
    int         test_errors;
    int         total_errors;
    int         tests_run;
    int         tests_failed;

    uart_bridge_slave i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped at the cycle limit of %0d, a test never finished", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic note_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("mismatch %s: expected %h, actual %h", name, exp, act);
        test_errors++;
    endtask

    task automatic note_failure(input string name, input string what);
        $display("error %s: %s", name, what);
        test_errors++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // frame bits go out msb first at one per cycle
    task automatic send_frame(input logic [2:0] code, input logic [IW-1:0] id,
                              input logic rw);
        logic [IW+3:0] frame;
        frame = {code, id, rw};
        for (int i = IW + 3; i >= 0; i--) begin
            @(posedge clk);
            control <= frame[i];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic run_write(input string name, input int mode);
        logic [DW-1:0] w;
        logic [DW-1:0] reply;
        int            idx;
        int            starts;
        int            delay;
        int            cyc;
        bit            done;
        w = $urandom;
        reply = 32'(ACK_WORD) | ($urandom & 32'hFFFF_FF00);
        if (mode == REPLY_WRONG) begin
            reply = $urandom;
            while (reply[7:0] == 8'hCC) begin
                reply = $urandom;
            end
        end
        idx = 0;
        starts = 0;
        delay = 0;
        cyc = 0;
        done = 1'b0;
        send_frame(3'b111, IW'(`BRIDGE_SLAVE_ID), 1'b1);
        while (!done && cyc < TASK_LIMIT) begin
            @(negedge clk);
            // the whole word is in, so the master lines must be closed
            if (ready && idx == DW) begin
                note_failure(name, "ready still high after the last write bit");
            end
            if (valid && ready) begin
                idx++;
            end
            if (s_txStart) begin
                starts++;
                if (s_byteForTx !== w) begin
                    note_mismatch(name, 64'(w), 64'(s_byteForTx));
                end
                if (mode != REPLY_NONE) begin
                    delay = 1 + int'($urandom % 10);
                end
            end
            if (i_dut.send_done) begin
                done = 1'b1;
            end
            @(posedge clk);
            s_rxDone <= 1'b0;
            if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    s_rxDone     <= 1'b1;
                    s_byteFromRx <= reply;
                end
            end
            s_txReady <= 1'($urandom % 2);
            if (idx < DW) begin
                valid <= ($urandom % 4) != 0;
                wD    <= w[DW-1-idx];
            end else begin
                valid <= 1'b0;
            end
            cyc++;
        end
        valid <= 1'b0;
        if (!done) begin
            note_failure(name, "write never reached its end");
        end
        if (idx != DW) begin
            note_mismatch(name, 64'(DW), 64'(idx));
        end
        if (mode == REPLY_NONE) begin
            if (starts != 1 + RETX) begin
                note_mismatch(name, 64'(1 + RETX), 64'(starts));
            end
        end else if (starts != 1) begin
            note_mismatch(name, 64'd1, 64'(starts));
        end
        exp_status = (mode == REPLY_ACK) ? 4'hC : 4'hA;
        close_test(name);
    endtask

    task automatic run_read(input string name);
        logic [DW-1:0]   w;
        logic [DW+3:0]   bits;
        int              n;
        int              delay;
        int              cyc;
        bit              started;
        bit              done;
        w = $urandom;
        bits = '0;
        n = 0;
        cyc = 0;
        started = 1'b0;
        done = 1'b0;
        delay = 3 + int'($urandom % 15);
        send_frame(3'b111, IW'(`BRIDGE_SLAVE_ID), 1'b0);
        while (!done && cyc < TASK_LIMIT) begin
            @(negedge clk);
            if (g_txStart) begin
                if (started) begin
                    note_failure(name, "second ack start in one read");
                end
                started = 1'b1;
                if (g_byteForTx !== ACK_WORD) begin
                    note_mismatch(name, 64'(ACK_WORD), 64'(g_byteForTx));
                end
            end else if (started) begin
                if (ready) begin
                    bits = {bits[DW+2:0], rD};
                    n++;
                end else begin
                    done = 1'b1;
                end
            end
            @(posedge clk);
            g_rxDone <= 1'b0;
            if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    g_rxDone     <= 1'b1;
                    g_byteFromRx <= w;
                end
            end
            g_txReady <= 1'($urandom % 2);
            cyc++;
        end
        if (!done) begin
            note_failure(name, "read never finished shifting out");
        end
        if (n != DW + 4) begin
            note_mismatch(name, 64'(DW + 4), 64'(n));
        end
        if (bits !== {exp_status, w}) begin
            note_mismatch(name, 64'({exp_status, w}), 64'(bits));
        end
        close_test(name);
    endtask

    task automatic run_ignored_frames(input string name);
        logic [DW-1:0] w;
        w = $urandom;
        // wrong id on a read, bad start code on a write
        send_frame(3'b111, IW'(2), 1'b0);
        send_frame(3'b101, IW'(`BRIDGE_SLAVE_ID), 1'b1);
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            if (ready || s_txStart || g_txStart || rD) begin
                note_failure(name, "slave reacted to a frame not meant for it");
            end
            @(posedge clk);
            // a word from the previous board that a wrongly taken read would answer
            g_rxDone <= 1'b0;
            if (i == 10) begin
                g_rxDone     <= 1'b1;
                g_byteFromRx <= w;
            end
            s_txReady <= 1'($urandom % 2);
            g_txReady <= 1'($urandom % 2);
        end
        close_test(name);
    endtask

    initial begin
        void'($urandom(36728));
        rstN         = 1'b0;
        control      = 1'b0;
        wD           = 1'b0;
        valid        = 1'b0;
        g_txReady    = 1'b0;
        g_rxStart    = 1'b0;
        g_rxDone     = 1'b0;
        g_byteFromRx = '0;
        g_rxReady    = 1'b0;
        s_rxStart    = 1'b0;
        s_rxDone     = 1'b0;
        s_byteFromRx = '0;
        s_rxReady    = 1'b0;
        s_txReady    = 1'b0;
        exp_status   = 4'h0;
        cycle_count  = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        repeat (3) @(posedge clk);

        run_read("read_after_reset");
        run_write("write_ack", REPLY_ACK);
        run_read("read_status_ack");
        run_write("write_wrong_reply", REPLY_WRONG);
        run_read("read_status_wrong");
        run_write("write_no_reply", REPLY_NONE);
        run_read("read_status_none");
        run_ignored_frames("ignored_frames");
        run_read("read_after_ignored");
        // a few extra rounds with a random reply mode
        for (int k = 0; k < 3; k++) begin
            run_write($sformatf("write_random_%0d", k), int'($urandom % 3));
            run_read($sformatf("read_random_%0d", k));
        end

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verif/uart_bridge_slave_assert.sv
`timescale 1ns/1ps

module uart_bridge_slave_assert (
    input logic clk,
    input logic rstN,
    input logic s_txStart,
    input logic s_txReady,
    input logic g_txStart,
    input logic g_txReady,
    input logic ready,
    input logic cmd_valid
);

    logic seen_cmd;

    // set once the first command has been decoded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            seen_cmd <= 1'b0;
        end else if (cmd_valid) begin
            seen_cmd <= 1'b1;
        end
    end

    s_start_pulse: assert property (@(posedge clk) disable iff (!rstN)
        s_txStart |=> !s_txStart)
        else $error("send-side start longer than one cycle");

    g_start_pulse: assert property (@(posedge clk) disable iff (!rstN)
        g_txStart |=> !g_txStart)
        else $error("get-side start longer than one cycle");

    s_start_needs_ready: assert property (@(posedge clk) disable iff (!rstN)
        s_txStart |-> s_txReady)
        else $error("send-side start while its transmitter was busy");

    g_start_needs_ready: assert property (@(posedge clk) disable iff (!rstN)
        g_txStart |-> g_txReady)
        else $error("get-side start while its transmitter was busy");

    quiet_before_cmd: assert property (@(posedge clk) disable iff (!rstN)
        !seen_cmd |-> !ready)
        else $error("ready raised before any command");

endmodule

bind uart_bridge_slave uart_bridge_slave_assert i_assert (
    .clk       (clk),
    .rstN      (rstN),
    .s_txStart (s_txStart),
    .s_txReady (s_txReady),
    .g_txStart (g_txStart),
    .g_txReady (g_txReady),
    .ready     (ready),
    .cmd_valid (cmd_valid)
);

//--- src/uart_bridge_slave.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module uart_bridge_slave (
    input  logic                          clk,
    input  logic                          rstN,
    // master lines
    input  logic                          control,
    input  logic                          wD,
    input  logic                          valid,
    output logic                          rD,
    output logic                          ready,
    // get-side uart, toward the previous board
    output logic                          g_txStart,
    output logic [`BRIDGE_DATA_WIDTH-1:0] g_byteForTx,
    input  logic                          g_txReady,
    input  logic                          g_rxStart,
    input  logic                          g_rxDone,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] g_byteFromRx,
    input  logic                          g_rxReady,
    // send-side uart, toward the next board
    input  logic                          s_rxStart,
    input  logic                          s_rxDone,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] s_byteFromRx,
    input  logic                          s_rxReady,
    output logic                          s_txStart,
    output logic [`BRIDGE_DATA_WIDTH-1:0] s_byteForTx,
    input  logic                          s_txReady
);

    logic                          cmd_valid;
    bridge_pkg::cmd_e              cmd_rw;
    logic [`BRIDGE_DATA_WIDTH-1:0] word;
    logic                          word_done;
    logic                          send_start;
    logic                          send_done;
    bridge_pkg::status_t           status;
    logic                          load;
    logic                          shift_done;
    logic [`BRIDGE_DATA_WIDTH-1:0] read_word;

    control_decoder u_ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .cmd_valid (cmd_valid),
        .cmd_rw    (cmd_rw)
    );

    write_deserializer u_wdes (
        .clk       (clk),
        .rstN      (rstN),
        .ready     (ready),
        .valid     (valid),
        .wD        (wD),
        .word      (word),
        .word_done (word_done)
    );

    ack_tracker u_ack (
        .clk          (clk),
        .rstN         (rstN),
        .send_start   (send_start),
        .s_txReady    (s_txReady),
        .s_rxDone     (s_rxDone),
        .word         (word),
        .s_byteFromRx (s_byteFromRx),
        .s_txStart    (s_txStart),
        .send_done    (send_done),
        .s_byteForTx  (s_byteForTx),
        .status       (status)
    );

    read_serializer u_rser (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .status     (status),
        .word       (read_word),
        .rD         (rD),
        .shift_done (shift_done)
    );

    bridge_sequencer u_seq (
        .clk          (clk),
        .rstN         (rstN),
        .cmd_valid    (cmd_valid),
        .cmd_rw       (cmd_rw),
        .word_done    (word_done),
        .send_done    (send_done),
        .g_rxDone     (g_rxDone),
        .g_txReady    (g_txReady),
        .shift_done   (shift_done),
        .g_byteFromRx (g_byteFromRx),
        .ready        (ready),
        .send_start   (send_start),
        .g_txStart    (g_txStart),
        .load         (load),
        .g_byteForTx  (g_byteForTx),
        .read_word    (read_word)
    );

endmodule

//--- src/bridge_sequencer.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module bridge_sequencer (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          cmd_valid,
    input  bridge_pkg::cmd_e              cmd_rw,
    input  logic                          word_done,
    input  logic                          send_done,
    input  logic                          g_rxDone,
    input  logic                          g_txReady,
    input  logic                          shift_done,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] g_byteFromRx,
    output logic                          ready,
    output logic                          send_start,
    output logic                          g_txStart,
    output logic                          load,
    output logic [`BRIDGE_DATA_WIDTH-1:0] g_byteForTx,
    output logic [`BRIDGE_DATA_WIDTH-1:0] read_word
);

    localparam int DW = `BRIDGE_DATA_WIDTH;

    bridge_pkg::state_e state;
    logic               ack_go;

    // master may move bits only while taking a word or shifting one out
    assign ready = (state == bridge_pkg::WRITE_IN) || (state == bridge_pkg::SHIFT_OUT);

    // ack to the previous board, and the serializer fills in the same cycle
    assign ack_go      = (state == bridge_pkg::SEND_ACK) && g_txReady;
    assign g_txStart   = ack_go;
    assign load        = ack_go;
    assign g_byteForTx = {{(DW - 8){1'b0}}, bridge_pkg::ACK_BYTE};

    always_ff @(posedge clk) begin
        if (state == bridge_pkg::READ_WAIT && g_rxDone) begin
            read_word <= g_byteFromRx;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= bridge_pkg::IDLE;
            send_start <= 1'b0;
        end else begin
            send_start <= 1'b0;
            case (state)
                bridge_pkg::IDLE: begin
                    // frames seen in any other state are dropped
                    if (cmd_valid) begin
                        if (cmd_rw == bridge_pkg::CMD_WRITE) begin
                            state <= bridge_pkg::WRITE_IN;
                        end else begin
                            state <= bridge_pkg::READ_WAIT;
                        end
                    end
                end
                bridge_pkg::WRITE_IN: begin
                    if (word_done) begin
                        send_start <= 1'b1;
                        state      <= bridge_pkg::SEND_WORD;
                    end
                end
                bridge_pkg::SEND_WORD: begin
                    if (send_done) begin
                        state <= bridge_pkg::IDLE;
                    end
                end
                bridge_pkg::READ_WAIT: begin
                    if (g_rxDone) begin
                        state <= bridge_pkg::SEND_ACK;
                    end
                end
                bridge_pkg::SEND_ACK: begin
                    if (ack_go) begin
                        state <= bridge_pkg::SHIFT_OUT;
                    end
                end
                bridge_pkg::SHIFT_OUT: begin
                    if (shift_done) begin
                        state <= bridge_pkg::IDLE;
                    end
                end
                default: state <= bridge_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- src/read_serializer.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module read_serializer (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          load,
    input  bridge_pkg::status_t           status,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] word,
    output logic                          rD,
    output logic                          shift_done
);

    localparam int DW    = `BRIDGE_DATA_WIDTH;
    localparam int LEN   = 4 + DW;
    localparam int CNT_W = $clog2(LEN);

    logic [LEN-1:0]   shreg;
    logic [CNT_W-1:0] bit_cnt;
    logic             active;

    // line idles low between reads
    assign rD         = active & shreg[LEN-1];
    assign shift_done = active && (bit_cnt == CNT_W'(LEN - 1));

    // status nibble leads, then the word, msb first
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {status, word};
        end else if (active) begin
            shreg <= {shreg[LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            active  <= 1'b1;
            bit_cnt <= '0;
        end else if (shift_done) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (active) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

//--- src/ack_tracker.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module ack_tracker (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          send_start,
    input  logic                          s_txReady,
    input  logic                          s_rxDone,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] word,
    input  logic [`BRIDGE_DATA_WIDTH-1:0] s_byteFromRx,
    output logic                          s_txStart,
    output logic                          send_done,
    output logic [`BRIDGE_DATA_WIDTH-1:0] s_byteForTx,
    output bridge_pkg::status_t           status
);

    localparam int TIMEOUT = `BRIDGE_ACK_TIMEOUT;
    localparam int RETX    = `BRIDGE_RETX_TIMES;
    localparam int TMR_W   = $clog2(TIMEOUT);
    localparam int RETX_W  = $clog2(RETX + 1);

    typedef enum logic [1:0] {
        TRK_IDLE,
        TRK_START,
        TRK_WAIT
    } trk_e;

    trk_e              phase;
    logic [TMR_W-1:0]  tmr;
    logic [RETX_W-1:0] retx_cnt;
    logic              ack_ok;
    logic              timed_out;

    // start only while the transmitter says it can take a byte
    assign s_txStart = (phase == TRK_START) && s_txReady;
    assign ack_ok    = (s_byteFromRx[7:0] == bridge_pkg::ACK_BYTE);
    assign timed_out = (tmr == TMR_W'(TIMEOUT - 1));

    // same word goes out on every retransmit
    always_ff @(posedge clk) begin
        if (send_start && phase == TRK_IDLE) begin
            s_byteForTx <= word;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase     <= TRK_IDLE;
            tmr       <= '0;
            retx_cnt  <= '0;
            send_done <= 1'b0;
            status    <= bridge_pkg::STATUS_NONE;
        end else begin
            send_done <= 1'b0;
            case (phase)
                TRK_IDLE: begin
                    if (send_start) begin
                        retx_cnt <= '0;
                        phase    <= TRK_START;
                    end
                end
                TRK_START: begin
                    if (s_txReady) begin
                        tmr   <= '0;
                        phase <= TRK_WAIT;
                    end
                end
                TRK_WAIT: begin
                    if (s_rxDone) begin
                        status    <= ack_ok ? bridge_pkg::STATUS_ACK : bridge_pkg::STATUS_NAK;
                        send_done <= 1'b1;
                        phase     <= TRK_IDLE;
                    end else if (timed_out) begin
                        // out of retries, the far board never answered
                        if (retx_cnt == RETX_W'(RETX)) begin
                            status    <= bridge_pkg::STATUS_NAK;
                            send_done <= 1'b1;
                            phase     <= TRK_IDLE;
                        end else begin
                            retx_cnt <= retx_cnt + 1'b1;
                            phase    <= TRK_START;
                        end
                    end else begin
                        tmr <= tmr + 1'b1;
                    end
                end
                default: phase <= TRK_IDLE;
            endcase
        end
    end

endmodule

//--- src/write_deserializer.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module write_deserializer (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          ready,
    input  logic                          valid,
    input  logic                          wD,
    output logic [`BRIDGE_DATA_WIDTH-1:0] word,
    output logic                          word_done
);

    localparam int DW    = `BRIDGE_DATA_WIDTH;
    localparam int CNT_W = $clog2(DW);

    logic [CNT_W-1:0] bit_cnt;
    logic             take;

    // a bit moves only when both sides agree
    assign take      = ready & valid;
    assign word_done = take && (bit_cnt == CNT_W'(DW - 1));

    // msb arrives first
    always_ff @(posedge clk) begin
        if (take) begin
            word <= {word[DW-2:0], wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
        end else if (word_done) begin
            bit_cnt <= '0;
        end else if (take) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

//--- src/control_decoder.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module control_decoder (
    input  logic             clk,
    input  logic             rstN,
    input  logic             control,
    output logic             cmd_valid,
    output bridge_pkg::cmd_e cmd_rw
);

    localparam int FRAME_LEN = `BRIDGE_FRAME_LEN;
    localparam int ID_W      = `BRIDGE_ID_WIDTH;
    localparam int CNT_W     = $clog2(FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_LEN - 1);

    logic [FRAME_LEN-2:0] shreg;
    logic [FRAME_LEN-1:0] frame;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 last_bit;
    logic                 match;

    // bits already taken plus the one on the line now
    assign frame    = {shreg, control};
    assign last_bit = (bit_cnt == LAST_BIT);

    // start code on top, id in the middle, r/w bit last
    assign match = (frame[FRAME_LEN-1 -: 3] == bridge_pkg::START) &&
                   (frame[ID_W:1] == ID_W'(`BRIDGE_SLAVE_ID));

    always_ff @(posedge clk) begin
        shreg <= frame[FRAME_LEN-2:0];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
            cmd_rw    <= bridge_pkg::CMD_READ;
        end else begin
            cmd_valid <= 1'b0;
            if (bit_cnt == '0) begin
                // first high bit opens a frame
                if (control) begin
                    bit_cnt <= CNT_W'(1);
                end
            end else if (last_bit) begin
                bit_cnt   <= '0;
                cmd_valid <= match;
                cmd_rw    <= bridge_pkg::cmd_e'(frame[0]);
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/bridge_pkg.sv
package bridge_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        WRITE_IN,
        SEND_WORD,
        READ_WAIT,
        SEND_ACK,
        SHIFT_OUT
    } state_e;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_e;

    // leading bits of a control frame
    typedef enum logic [2:0] {
        START = 3'b111
    } ctrl_code_e;

    typedef enum logic [7:0] {
        ACK_BYTE = 8'b1100_1100,
        NAK_BYTE = 8'b1010_1010
    } ack_byte_e;

    // upper nibble of the reply byte, reported to the master on read
    typedef enum logic [3:0] {
        STATUS_NONE = 4'b0000,
        STATUS_ACK  = 4'b1100,
        STATUS_NAK  = 4'b1010
    } status_t;

endpackage

//--- src/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// word carried over both the master lines and the uart links
`define BRIDGE_DATA_WIDTH 32

// slave address field in the control frame
`define BRIDGE_ID_WIDTH 2
`define BRIDGE_SLAVE_ID 1

// start code, id and read/write bit
`define BRIDGE_FRAME_LEN 6

// cycles to wait for an acknowledge before sending again
`define BRIDGE_ACK_TIMEOUT 24
`define BRIDGE_RETX_TIMES 3

`endif
